//--- design/mult_defs.svh
`ifndef MULT_DEFS_SVH
`define MULT_DEFS_SVH

// operand and product sizes
`define OPERAND_WIDTH 16
`define PRODUCT_WIDTH 32

// each operand is split in two halves, one tree per pair of halves
`define QUARTER_WIDTH 8
`define QUARTER_COUNT 4

// sampling edge of inValid counts as the first
`define PIPE_LATENCY 3

`endif

//--- design/multPkg.sv
`include "mult_defs.svh"

package multPkg;

  typedef logic signed [`OPERAND_WIDTH-1:0] operandT;
  // -32768 becomes 32768, so no sign bit here
  typedef logic [`OPERAND_WIDTH-1:0] magnitudeT;
  typedef logic [`QUARTER_WIDTH-1:0] quarterT;
  typedef logic [2*`QUARTER_WIDTH-1:0] quarterProductT;
  typedef logic signed [`PRODUCT_WIDTH-1:0] productT;

  // stage 1 result
  typedef struct packed {
    magnitudeT aMag;
    magnitudeT bMag;
    logic      negate;
  } prepWordT;

  // 3:2 counter, returns {carry, sum}
  function automatic logic [1:0] fullAdd(input logic x, input logic y, input logic z);
    logic sum;
    logic carry;
    sum   = x ^ y ^ z;
    carry = (x & y) | (x & z) | (y & z);
    return {carry, sum};
  endfunction

  // 2:2 counter, returns {carry, sum}
  function automatic logic [1:0] halfAdd(input logic x, input logic y);
    logic sum;
    logic carry;
    sum   = x ^ y;
    carry = x & y;
    return {carry, sum};
  endfunction

endpackage

//--- design/operandPrep.sv
`include "mult_defs.svh"

module operandPrep (
  input  logic              clk,
  input  logic              rstN,
  input  multPkg::operandT  opA,
  input  multPkg::operandT  opB,
  input  logic              inValid,
  output multPkg::prepWordT prep,
  output logic              prepValid
);
  import multPkg::*;

  logic      signA;
  logic      signB;
  magnitudeT aMag;
  magnitudeT bMag;
  prepWordT  prepNext;

  assign signA = opA[`OPERAND_WIDTH-1];
  assign signB = opB[`OPERAND_WIDTH-1];

  // conditional two's complement of negative operands
  assign aMag = signA ? ~opA + 1'b1 : opA;
  assign bMag = signB ? ~opB + 1'b1 : opB;

  assign prepNext.aMag   = aMag;
  assign prepNext.bMag   = bMag;
  assign prepNext.negate = signA ^ signB;

  always_ff @(posedge clk)
  begin
    if (!rstN)
    begin
      prepValid <= 1'b0;
    end
    else
    begin
      prepValid <= inValid;
    end
  end

  // only load on a new operation
  always_ff @(posedge clk)
  begin
    if (inValid)
    begin
      prep <= prepNext;
    end
  end

endmodule

//--- design/daddaTree8.sv
module daddaTree8 (
  input  logic                    clk,
  input  multPkg::quarterT        a,
  input  multPkg::quarterT        b,
  output multPkg::quarterProductT quarterProduct
);
  import multPkg::*;

  // pp[row][col] has weight row + col
  logic [7:0]     pp [8];
  logic [0:5]     s1;
  logic [0:5]     c1;
  logic [0:13]    s2;
  logic [0:13]    c2;
  logic [0:9]     s3;
  logic [0:9]     c3;
  logic [0:11]    s4;
  logic [0:11]    c4;
  logic [0:13]    c5;
  quarterProductT sumWord;

  for (genvar row = 0; row < 8; row++)
  begin : genRow
    for (genvar col = 0; col < 8; col++)
    begin : genCol
      assign pp[row][col] = a[col] & b[row];
    end
  end

  // height 8 down to 6
  assign {c1[0], s1[0]} = halfAdd(pp[6][0], pp[5][1]);
  assign {c1[1], s1[1]} = fullAdd(pp[7][0], pp[6][1], pp[5][2]);
  assign {c1[2], s1[2]} = halfAdd(pp[4][3], pp[3][4]);
  assign {c1[3], s1[3]} = fullAdd(pp[7][1], pp[6][2], pp[5][3]);
  assign {c1[4], s1[4]} = halfAdd(pp[4][4], pp[3][5]);
  assign {c1[5], s1[5]} = fullAdd(pp[7][2], pp[6][3], pp[5][4]);

  // height 6 down to 4
  assign {c2[0], s2[0]}   = halfAdd(pp[4][0], pp[3][1]);
  assign {c2[1], s2[1]}   = fullAdd(pp[5][0], pp[4][1], pp[3][2]);
  assign {c2[2], s2[2]}   = halfAdd(pp[2][3], pp[1][4]);
  assign {c2[3], s2[3]}   = fullAdd(s1[0], pp[4][2], pp[3][3]);
  assign {c2[4], s2[4]}   = fullAdd(pp[2][4], pp[1][5], pp[0][6]);
  assign {c2[5], s2[5]}   = fullAdd(s1[1], s1[2], c1[0]);
  assign {c2[6], s2[6]}   = fullAdd(pp[2][5], pp[1][6], pp[0][7]);
  assign {c2[7], s2[7]}   = fullAdd(s1[3], s1[4], c1[1]);
  assign {c2[8], s2[8]}   = fullAdd(c1[2], pp[2][6], pp[1][7]);
  assign {c2[9], s2[9]}   = fullAdd(s1[5], c1[3], c1[4]);
  assign {c2[10], s2[10]} = fullAdd(pp[4][5], pp[3][6], pp[2][7]);
  assign {c2[11], s2[11]} = fullAdd(pp[7][3], c1[5], pp[6][4]);
  assign {c2[12], s2[12]} = fullAdd(pp[5][5], pp[4][6], pp[3][7]);
  assign {c2[13], s2[13]} = fullAdd(pp[7][4], pp[6][5], pp[5][6]);

  // height 4 down to 3
  assign {c3[0], s3[0]} = halfAdd(pp[3][0], pp[2][1]);
  assign {c3[1], s3[1]} = fullAdd(s2[0], pp[2][2], pp[1][3]);
  assign {c3[2], s3[2]} = fullAdd(s2[1], s2[2], c2[0]);
  assign {c3[3], s3[3]} = fullAdd(c2[1], c2[2], s2[3]);
  assign {c3[4], s3[4]} = fullAdd(c2[3], c2[4], s2[5]);
  assign {c3[5], s3[5]} = fullAdd(c2[5], c2[6], s2[7]);
  assign {c3[6], s3[6]} = fullAdd(c2[7], c2[8], s2[9]);
  assign {c3[7], s3[7]} = fullAdd(c2[9], c2[10], s2[11]);
  assign {c3[8], s3[8]} = fullAdd(c2[11], c2[12], s2[13]);
  assign {c3[9], s3[9]} = fullAdd(pp[7][5], pp[6][6], pp[5][7]);

  // height 3 down to 2
  assign {c4[0], s4[0]}   = halfAdd(pp[2][0], pp[1][1]);
  assign {c4[1], s4[1]}   = fullAdd(s3[0], pp[1][2], pp[0][3]);
  assign {c4[2], s4[2]}   = fullAdd(c3[0], s3[1], pp[0][4]);
  assign {c4[3], s4[3]}   = fullAdd(c3[1], s3[2], pp[0][5]);
  assign {c4[4], s4[4]}   = fullAdd(c3[2], s3[3], s2[4]);
  assign {c4[5], s4[5]}   = fullAdd(c3[3], s3[4], s2[6]);
  assign {c4[6], s4[6]}   = fullAdd(c3[4], s3[5], s2[8]);
  assign {c4[7], s4[7]}   = fullAdd(c3[5], s3[6], s2[10]);
  assign {c4[8], s4[8]}   = fullAdd(c3[6], s3[7], s2[12]);
  assign {c4[9], s4[9]}   = fullAdd(c3[7], s3[8], pp[4][7]);
  assign {c4[10], s4[10]} = fullAdd(c3[8], s3[9], c2[13]);
  assign {c4[11], s4[11]} = fullAdd(c3[9], pp[7][6], pp[6][7]);

  // final carry row over the last two rows
  assign sumWord[0] = pp[0][0];
  assign {c5[0], sumWord[1]}   = halfAdd(pp[1][0], pp[0][1]);
  assign {c5[1], sumWord[2]}   = fullAdd(s4[0], pp[0][2], c5[0]);
  assign {c5[2], sumWord[3]}   = fullAdd(c4[0], s4[1], c5[1]);
  assign {c5[3], sumWord[4]}   = fullAdd(c4[1], s4[2], c5[2]);
  assign {c5[4], sumWord[5]}   = fullAdd(c4[2], s4[3], c5[3]);
  assign {c5[5], sumWord[6]}   = fullAdd(c4[3], s4[4], c5[4]);
  assign {c5[6], sumWord[7]}   = fullAdd(c4[4], s4[5], c5[5]);
  assign {c5[7], sumWord[8]}   = fullAdd(c4[5], s4[6], c5[6]);
  assign {c5[8], sumWord[9]}   = fullAdd(c4[6], s4[7], c5[7]);
  assign {c5[9], sumWord[10]}  = fullAdd(c4[7], s4[8], c5[8]);
  assign {c5[10], sumWord[11]} = fullAdd(c4[8], s4[9], c5[9]);
  assign {c5[11], sumWord[12]} = fullAdd(c4[9], s4[10], c5[10]);
  assign {c5[12], sumWord[13]} = fullAdd(c4[10], s4[11], c5[11]);
  assign {c5[13], sumWord[14]} = fullAdd(c4[11], pp[7][7], c5[12]);
  assign sumWord[15] = c5[13];

  always_ff @(posedge clk)
  begin
    quarterProduct <= sumWord;
  end

endmodule

//--- design/productMerge.sv
`include "mult_defs.svh"

module productMerge (
  input  logic                    clk,
  input  logic                    rstN,
  input  multPkg::quarterProductT quarterProducts [`QUARTER_COUNT],
  input  logic                    negate,
  input  logic                    prepValid,
  output multPkg::productT        product,
  output logic                    outValid
);
  import multPkg::*;

  logic           negateD;
  logic           validD;
  // named after which halves of a and b went in
  quarterProductT lowLow;
  quarterProductT lowHigh;
  quarterProductT highLow;
  quarterProductT highHigh;
  quarterProductT upperRow;
  quarterProductT sumRow;
  quarterProductT carryRow;
  logic [21:0]    rippleCarry;
  productT        magnitude;

  assign lowLow   = quarterProducts[0];
  assign lowHigh  = quarterProducts[1];
  assign highLow  = quarterProducts[2];
  assign highHigh = quarterProducts[3];

  // bits 8..23 see three rows, highHigh takes over above lowLow
  assign upperRow = {highHigh[7:0], lowLow[15:8]};

  always_comb
  begin : mergeRows
    logic [1:0] topPair;
    magnitude[7:0] = lowLow[7:0];
    for (int k = 0; k < 16; k++)
    begin
      {carryRow[k], sumRow[k]} = fullAdd(upperRow[k], lowHigh[k], highLow[k]);
    end
    magnitude[8] = sumRow[0];
    {rippleCarry[0], magnitude[9]} = halfAdd(sumRow[1], carryRow[0]);
    for (int k = 1; k < 15; k++)
    begin
      {rippleCarry[k], magnitude[k + 9]} = fullAdd(sumRow[k + 1], carryRow[k], rippleCarry[k - 1]);
    end
    {rippleCarry[15], magnitude[24]} = fullAdd(highHigh[8], carryRow[15], rippleCarry[14]);
    // only highHigh is left above bit 24
    for (int k = 16; k < 22; k++)
    begin
      {rippleCarry[k], magnitude[k + 9]} = halfAdd(highHigh[k - 7], rippleCarry[k - 1]);
    end
    // carry out of bit 31 is always zero for a 16x16 magnitude product
    topPair = halfAdd(highHigh[15], rippleCarry[21]);
    magnitude[31] = topPair[0];
  end

  always_ff @(posedge clk)
  begin
    if (!rstN)
    begin
      validD   <= 1'b0;
      outValid <= 1'b0;
    end
    else
    begin
      validD   <= prepValid;
      outValid <= validD;
    end
  end

  // negate travels beside the tree registers
  always_ff @(posedge clk)
  begin
    negateD <= negate;
    if (validD)
    begin
      product <= negateD ? ~magnitude + 1'b1 : magnitude;
    end
  end

endmodule

//--- design/signedMultiplier16.sv
`include "mult_defs.svh"

module signedMultiplier16 (
  input  logic             clk,
  input  logic             rstN,
  input  multPkg::operandT opA,
  input  multPkg::operandT opB,
  input  logic             inValid,
  output multPkg::productT product,
  output logic             outValid
);
  import multPkg::*;

  prepWordT       prep;
  logic           prepValid;
  quarterProductT quarterProducts [`QUARTER_COUNT];

  operandPrep operandPrep_inst (
    .clk       (clk),
    .rstN      (rstN),
    .opA       (opA),
    .opB       (opB),
    .inValid   (inValid),
    .prep      (prep),
    .prepValid (prepValid)
  );

  // bit 1 of the index picks the a half, bit 0 the b half
  for (genvar i = 0; i < `QUARTER_COUNT; i++)
  begin : genTree
    daddaTree8 daddaTree8_inst (
      .clk            (clk),
      .a              (prep.aMag[(i / 2) * `QUARTER_WIDTH +: `QUARTER_WIDTH]),
      .b              (prep.bMag[(i % 2) * `QUARTER_WIDTH +: `QUARTER_WIDTH]),
      .quarterProduct (quarterProducts[i])
    );
  end

  productMerge productMerge_inst (
    .clk             (clk),
    .rstN            (rstN),
    .quarterProducts (quarterProducts),
    .negate          (prep.negate),
    .prepValid       (prepValid),
    .product         (product),
    .outValid        (outValid)
  );

endmodule

//--- tests/signedMultiplier16Tb.sv
`include "mult_defs.svh"

module signedMultiplier16Tb;
  timeunit 1ns;
  timeprecision 1ps;

  import multPkg::*;

  localparam int PATTERN_COUNT = 38;
  localparam int RANDOM_COUNT  = 200;
  localparam int RESET_CYCLES  = 4;
  localparam int MAX_GAP       = 3;
  localparam int LATENCY_RUNS  = 4;
  localparam int DRIVE_DELAY   = 2;
  // reset, directed burst, isolated runs, gapped random traffic, drains and margin
  localparam int WATCHDOG_CYCLES = RESET_CYCLES + 4 + PATTERN_COUNT + 2 * `PIPE_LATENCY
                                   + LATENCY_RUNS * (2 * `PIPE_LATENCY + 4)
                                   + RANDOM_COUNT * (MAX_GAP + 1)
                                   + 3 * `PIPE_LATENCY + 20;

  logic    clk;
  logic    rstN;
  operandT opA;
  operandT opB;
  logic    inValid;
  productT product;
  logic    outValid;

  // opA, opB and expected product for each pattern
  logic [31:0] patternWords [3*PATTERN_COUNT];
  productT     expectQ [$];
  string       nameQ [$];
  logic [31:0] lcgState;

  signedMultiplier16 signedMultiplier16_inst (
    .clk      (clk),
    .rstN     (rstN),
    .opA      (opA),
    .opB      (opB),
    .inValid  (inValid),
    .product  (product),
    .outValid (outValid)
  );

  always #10 clk = ~clk;

  task automatic abortRun(input string reason);
    $display("%s", reason);
    $display("FAIL: see errors above");
    $fatal(1);
  endtask

  task automatic checkProduct(input productT expected, input productT actual, input string name);
    if (actual !== expected)
    begin
      $display("CHECK FAILED %s: expected %0d (%h) actual %0d (%h)",
               name, expected, expected, actual, actual);
      abortRun("product mismatch");
    end
  endtask

  task automatic checkValid(input logic expected, input logic actual, input string name);
    if (actual !== expected)
    begin
      $display("CHECK FAILED %s: expected outValid %b actual %b", name, expected, actual);
      abortRun("outValid mismatch");
    end
  endtask

  function automatic logic [31:0] nextRandom();
    lcgState = lcgState * 32'd1664525 + 32'd1013904223;
    return lcgState;
  endfunction

  // signed product straight from the operand values
  function automatic productT signedProduct(input operandT a, input operandT b);
    productT wideA;
    productT wideB;
    wideA = a;
    wideB = b;
    return wideA * wideB;
  endfunction

  task automatic issueOp(input operandT a, input operandT b, input productT expected,
                         input string name);
    @(posedge clk);
    #DRIVE_DELAY;
    opA     = a;
    opB     = b;
    inValid = 1'b1;
    expectQ.push_back(expected);
    nameQ.push_back(name);
  endtask

  task automatic idleCycle();
    @(posedge clk);
    #DRIVE_DELAY;
    inValid = 1'b0;
  endtask

  task automatic issuePattern(input int index);
    operandT a;
    operandT b;
    productT expected;
    a        = patternWords[3*index][15:0];
    b        = patternWords[3*index+1][15:0];
    expected = patternWords[3*index+2];
    issueOp(a, b, expected, $sformatf("pattern %0d", index));
  endtask

  task automatic waitIdle();
    while (expectQ.size() != 0)
    begin
      @(negedge clk);
    end
  endtask

  // outValid holds for as many cycles as patterns issued back to back
  task automatic runBackToBack();
    fork
      begin
        for (int i = 0; i < PATTERN_COUNT; i++)
        begin
          issuePattern(i);
        end
        idleCycle();
      end
      begin
        do
        begin
          @(negedge clk);
        end
        while (outValid !== 1'b1);
        for (int k = 1; k < PATTERN_COUNT; k++)
        begin
          @(negedge clk);
          checkValid(1'b1, outValid, $sformatf("burst cycle %0d", k));
        end
        @(negedge clk);
        checkValid(1'b0, outValid, "burst end");
      end
    join
  endtask

  task automatic runLatency(input int index);
    waitIdle();
    issuePattern(index);
    // this edge samples inValid
    idleCycle();
    for (int k = 0; k <= `PIPE_LATENCY; k++)
    begin
      @(negedge clk);
      checkValid(k == `PIPE_LATENCY - 1, outValid,
                 $sformatf("latency pattern %0d edge %0d", index, k + 1));
    end
  endtask

  task automatic runRandom();
    logic [31:0] r;
    operandT     a;
    operandT     b;
    int          gap;
    for (int i = 0; i < RANDOM_COUNT; i++)
    begin
      r   = nextRandom();
      a   = r[31:16];
      r   = nextRandom();
      b   = r[31:16];
      r   = nextRandom();
      gap = r[29:28];
      issueOp(a, b, signedProduct(a, b), $sformatf("random %0d (%0d * %0d)", i, a, b));
      repeat (gap) idleCycle();
    end
    idleCycle();
  endtask

  // results are popped in issue order
  always @(negedge clk)
  begin
    if (rstN === 1'b1 && outValid === 1'b1)
    begin
      if (expectQ.size() == 0)
      begin
        abortRun($sformatf("outValid high at %0t with no operation in flight", $time));
      end
      else
      begin
        checkProduct(expectQ.pop_front(), product, nameQ.pop_front());
      end
    end
  end

  initial
  begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    abortRun("watchdog timeout: results did not arrive");
  end

  initial
  begin
    clk      = 1'b0;
    rstN     = 1'b0;
    opA      = '0;
    opB      = '0;
    inValid  = 1'b0;
    lcgState = 32'hc431;

    $readmemh("tests/multPatterns.txt", patternWords);
    if ($isunknown(patternWords[3*PATTERN_COUNT-1]))
    begin
      abortRun("pattern file tests/multPatterns.txt could not be read");
    end

    repeat (RESET_CYCLES) @(posedge clk);
    #DRIVE_DELAY;
    checkValid(1'b0, outValid, "during reset");
    rstN = 1'b1;
    repeat (4)
    begin
      @(negedge clk);
      checkValid(1'b0, outValid, "idle after reset");
    end

    runBackToBack();
    for (int i = 0; i < LATENCY_RUNS; i++)
    begin
      runLatency(8 + i);
    end
    waitIdle();
    runRandom();

    repeat (`PIPE_LATENCY + 2) @(negedge clk);
    if (expectQ.size() == 0)
    begin
      $display("PASS: all tests");
      $finish;
    end
    else
    begin
      abortRun($sformatf("%0d results never arrived, first is %s",
                         expectQ.size(), nameQ[0]));
    end
  end

endmodule

//--- tests/multPatterns.txt
// columns: opA opB expected product, all hex, two's complement
// opA and opB are 16 bits, the product is 32 bits
0000 0000 00000000
0000 7fff 00000000
8000 0000 00000000
0001 0001 00000001
ffff 0001 ffffffff
0001 ffff ffffffff
ffff ffff 00000001
00ff 00ff 0000fe01
8000 8000 40000000
8000 7fff c0008000
7fff 8000 c0008000
7fff 7fff 3fff0001
8000 0001 ffff8000
8000 ffff 00008000
ffff 8000 00008000
0002 0003 00000006
fffe 0003 fffffffa
0002 fffd fffffffa
fffe fffd 00000006
0100 0100 00010000
0080 0080 00004000
00ff 0100 0000ff00
ff00 0100 ffff0000
1234 0010 00012340
1234 ffff ffffedcc
00ff ff01 ffff01ff
ff01 ff01 0000fe01
0100 8000 ff800000
4000 4000 10000000
c000 4000 f0000000
c000 c000 10000000
5555 0003 0000ffff
aaab 0003 ffff0001
0101 0101 00010201
7fff ffff ffff8001
8001 8001 3fff0001
1000 0fff 00fff000
00f0 000f 00000e10

//--- src.f
+incdir+design
design/multPkg.sv
design/operandPrep.sv
design/daddaTree8.sv
design/productMerge.sv
design/signedMultiplier16.sv
tests/signedMultiplier16Tb.sv
